// ==== aqp_pkg.sv ====
package aqp_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////////////
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;
    localparam int PAGE_W = 6;
    localparam int BA_W   = 5;                  // 512KB in 16KB pages

    //////////////////////////////////////////////////////////////////////
    // I/O port map
    //////////////////////////////////////////////////////////////////////
    localparam logic [7:0] IO_BANK0    = 8'hF0; // Banks 1-3 at $F1-$F3
    localparam logic [7:0] IO_KBBUF    = 8'hFA;
    localparam logic [7:0] IO_SYSCTRL  = 8'hFB;
    localparam logic [7:0] IO_CASSETTE = 8'hFC;
    localparam logic [7:0] IO_PRINTER  = 8'hFE;
    localparam logic [7:0] IO_KEYB     = 8'hFF;

    // Page map
    localparam int PAGE_CART_FIRST = 16;
    localparam int PAGE_CART_LAST  = 19;
    localparam int PAGE_RAM_FIRST  = 32;

    localparam logic [DATA_W-1:0] READ_IDLE = 8'hFF;

    // Keyboard buffer
    localparam int KBBUF_DEPTH = 16;
    localparam int KBBUF_PTR_W = $clog2(KBBUF_DEPTH);

    // phi generation, in clk cycles per half period
    localparam int PHI_HALF_NORMAL = 4;
    localparam int PHI_HALF_TURBO  = 2;
    localparam int PHI_CNT_W       = $clog2(PHI_HALF_NORMAL);

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    // Per bank: bit 7 read-only, bit 6 unused, bits 5:0 page
    typedef logic [3:0][7:0] bank_set_t;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_SYNC,
        BUS_ACCESS,
        BUS_HOLD
    } bus_state_t;

    typedef enum logic [2:0] {
        IO_SEL_NONE,
        IO_SEL_BANK,
        IO_SEL_KBBUF,
        IO_SEL_SYSCTRL,
        IO_SEL_CASSETTE,
        IO_SEL_PRINTER,
        IO_SEL_KEYB
    } io_sel_t;

endpackage

// ==== bus_cycle_fsm.sv ====
module bus_cycle_fsm (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req,
    input  logic                      rd,
    input  logic                      mem,
    input  logic [aqp_pkg::ADDR_W-1:0] addr,
    input  logic [aqp_pkg::DATA_W-1:0] wrdata,
    output logic                      ack,
    output logic                      cyc_active,
    output logic                      cyc_rd,
    output logic                      cyc_mem,
    output logic [aqp_pkg::ADDR_W-1:0] cyc_addr,
    output logic [aqp_pkg::DATA_W-1:0] cyc_wrdata,
    output logic                      rd_stb,
    output logic                      wr_stb
);

    aqp_pkg::bus_state_t state;
    logic [1:0]          req_sync;

    //////////////////////////////////////////////////////////////////////
    // Handshake state machine
    //////////////////////////////////////////////////////////////////////

    // First sync stage opens the cycle, second stage confirms and ends it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_sync <= 2'b00;
            state    <= aqp_pkg::BUS_IDLE;
        end else begin
            req_sync <= {req_sync[0], req};
            case (state)
                aqp_pkg::BUS_IDLE:   if (req_sync[0]) state <= aqp_pkg::BUS_SYNC;
                aqp_pkg::BUS_SYNC:   if (req_sync[1]) state <= aqp_pkg::BUS_ACCESS;
                aqp_pkg::BUS_ACCESS: state <= aqp_pkg::BUS_HOLD;
                aqp_pkg::BUS_HOLD:   if (!req_sync[1]) state <= aqp_pkg::BUS_IDLE;
                default:             state <= aqp_pkg::BUS_IDLE;
            endcase
        end
    end

    // Access captured on the way into BUS_SYNC
    always_ff @(posedge clk) begin
        if (state == aqp_pkg::BUS_IDLE && req_sync[0]) begin
            cyc_rd     <= rd;
            cyc_mem    <= mem;
            cyc_addr   <= addr;
            cyc_wrdata <= wrdata;
        end
    end

    assign cyc_active = (state != aqp_pkg::BUS_IDLE);
    assign ack        = (state == aqp_pkg::BUS_HOLD);   // Held until req drops

    // One strobe per cycle, in BUS_ACCESS only
    assign rd_stb = (state == aqp_pkg::BUS_ACCESS) &&  cyc_rd;
    assign wr_stb = (state == aqp_pkg::BUS_ACCESS) && !cyc_rd;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////
    ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        ack |-> cyc_active);

    strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(rd_stb && wr_stb));

endmodule

// ==== phi_timer.sv ====
module phi_timer (
    input  logic clk,
    input  logic reset,
    input  logic turbo,
    output logic phi
);

    logic [aqp_pkg::PHI_CNT_W-1:0] cnt;
    logic [aqp_pkg::PHI_CNT_W-1:0] reload;

    // Rate is picked up only at reload, so phi never gets a short half
    assign reload = turbo ? aqp_pkg::PHI_CNT_W'(aqp_pkg::PHI_HALF_TURBO - 1)
                          : aqp_pkg::PHI_CNT_W'(aqp_pkg::PHI_HALF_NORMAL - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt <= aqp_pkg::PHI_CNT_W'(aqp_pkg::PHI_HALF_NORMAL - 1);
            phi <= 1'b0;
        end else if (cnt == '0) begin
            cnt <= reload;
            phi <= ~phi;                    // Half period done
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

// ==== addr_decode.sv ====
module addr_decode (
    input  logic                       cyc_active,
    input  logic                       cyc_rd,
    input  logic                       cyc_mem,
    input  logic [aqp_pkg::ADDR_W-1:0] cyc_addr,
    input  aqp_pkg::bank_set_t         banks,
    input  logic                       dis_regs,
    output aqp_pkg::io_sel_t           io_sel,
    output logic [1:0]                 bank_idx,
    output logic [aqp_pkg::BA_W-1:0]   ba,
    output logic                       ram_ce_n,
    output logic                       cart_ce_n,
    output logic                       ram_we_n
);

    logic [7:0]                 bank;
    logic [aqp_pkg::PAGE_W-1:0] page;
    logic                       bank_ro;
    logic                       sel_mem;
    logic                       sel_ram;
    logic                       sel_cart;

    //////////////////////////////////////////////////////////////////////
    // Memory space
    //////////////////////////////////////////////////////////////////////
    assign bank    = banks[cyc_addr[aqp_pkg::ADDR_W-1 -: 2]];  // Quarter of 64KB
    assign page    = bank[aqp_pkg::PAGE_W-1:0];
    assign bank_ro = bank[7];
    assign ba      = page[aqp_pkg::BA_W-1:0];

    assign sel_mem  = cyc_active && cyc_mem;
    assign sel_ram  = sel_mem && page >= aqp_pkg::PAGE_W'(aqp_pkg::PAGE_RAM_FIRST);
    assign sel_cart = sel_mem
                   && page >= aqp_pkg::PAGE_W'(aqp_pkg::PAGE_CART_FIRST)
                   && page <= aqp_pkg::PAGE_W'(aqp_pkg::PAGE_CART_LAST);

    // Internal pages select nothing and read back idle
    assign ram_ce_n  = !sel_ram;
    assign cart_ce_n = !sel_cart;
    assign ram_we_n  = !(sel_ram && !cyc_rd && !bank_ro);

    // Bank port number for I/O accesses
    assign bank_idx = cyc_addr[1:0];

    //////////////////////////////////////////////////////////////////////
    // I/O space
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        io_sel = aqp_pkg::IO_SEL_NONE;
        if (cyc_active && !cyc_mem) begin
            if (cyc_addr[7:2] == aqp_pkg::IO_BANK0[7:2] && !dis_regs)
                io_sel = aqp_pkg::IO_SEL_BANK;
            else if (cyc_addr[7:0] == aqp_pkg::IO_KBBUF)
                io_sel = aqp_pkg::IO_SEL_KBBUF;
            else if (cyc_addr[7:0] == aqp_pkg::IO_SYSCTRL)
                io_sel = aqp_pkg::IO_SEL_SYSCTRL;
            else if (cyc_addr[7:0] == aqp_pkg::IO_CASSETTE)
                io_sel = aqp_pkg::IO_SEL_CASSETTE;
            else if (cyc_addr[7:0] == aqp_pkg::IO_PRINTER)
                io_sel = aqp_pkg::IO_SEL_PRINTER;
            else if (cyc_addr[7:0] == aqp_pkg::IO_KEYB)
                io_sel = aqp_pkg::IO_SEL_KEYB;  // Row mask in upper address
        end
    end

endmodule

// ==== io_regs.sv ====
module io_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       rd_stb,
    input  logic                       wr_stb,
    input  aqp_pkg::io_sel_t           io_sel,
    input  logic [1:0]                 bank_idx,
    input  logic [aqp_pkg::ADDR_W-1:0] cyc_addr,
    input  logic [aqp_pkg::DATA_W-1:0] cyc_wrdata,
    input  logic [63:0]                keys,
    input  logic                       cassette_in,
    input  logic                       printer_in,
    input  logic [aqp_pkg::DATA_W-1:0] kb_head,
    input  logic                       kb_empty,
    output aqp_pkg::bank_set_t         banks,
    output logic                       dis_regs,
    output logic                       turbo,
    output logic                       cassette_out,
    output logic                       printer_out,
    output logic                       reset_req,
    output logic                       kb_pop,
    output logic                       kb_clear,
    output logic [aqp_pkg::DATA_W-1:0] rddata
);

    logic [2:0]                 cassette_sync;
    logic [2:0]                 printer_sync;
    logic [aqp_pkg::DATA_W-1:0] keyb_val;
    logic [aqp_pkg::DATA_W-1:0] rd_val;

    //////////////////////////////////////////////////////////////////////
    // Keyboard matrix and read mux
    //////////////////////////////////////////////////////////////////////

    // Rows are active low, a zero address bit selects its row
    always_comb begin
        keyb_val = '1;
        for (int row = 0; row < 8; row++) begin
            if (!cyc_addr[8 + row])
                keyb_val = keyb_val & keys[row * 8 +: 8];
        end
    end

    always_comb begin
        rd_val = aqp_pkg::READ_IDLE;
        case (io_sel)
            aqp_pkg::IO_SEL_BANK:     rd_val = banks[bank_idx];
            aqp_pkg::IO_SEL_KBBUF:    rd_val = kb_head;
            aqp_pkg::IO_SEL_SYSCTRL:  rd_val = {5'b0, turbo, 1'b0, dis_regs};
            aqp_pkg::IO_SEL_CASSETTE: rd_val = {7'b0, !cassette_sync[2]};
            aqp_pkg::IO_SEL_PRINTER:  rd_val = {7'b0, printer_sync[2]};
            aqp_pkg::IO_SEL_KEYB:     rd_val = keyb_val;
            default:                  rd_val = aqp_pkg::READ_IDLE;
        endcase
    end

    // Buffer side effects
    assign kb_pop   = rd_stb && io_sel == aqp_pkg::IO_SEL_KBBUF && !kb_empty;
    assign kb_clear = wr_stb && io_sel == aqp_pkg::IO_SEL_KBBUF;

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cassette_sync <= 3'b000;
            printer_sync  <= 3'b000;
            banks         <= '0;
            dis_regs      <= 1'b0;
            turbo         <= 1'b0;
            cassette_out  <= 1'b0;
            printer_out   <= 1'b0;
            reset_req     <= 1'b0;
            rddata        <= '0;
        end else begin
            cassette_sync <= {cassette_sync[1:0], cassette_in};
            printer_sync  <= {printer_sync[1:0], printer_in};
            reset_req     <= wr_stb && io_sel == aqp_pkg::IO_SEL_SYSCTRL && cyc_wrdata[7];

            if (rd_stb)
                rddata <= rd_val;               // Held through BUS_HOLD

            if (wr_stb) begin
                case (io_sel)
                    aqp_pkg::IO_SEL_BANK:     banks[bank_idx] <= cyc_wrdata;
                    aqp_pkg::IO_SEL_CASSETTE: cassette_out <= cyc_wrdata[0];
                    aqp_pkg::IO_SEL_PRINTER:  printer_out  <= cyc_wrdata[0];
                    aqp_pkg::IO_SEL_SYSCTRL: begin
                        turbo    <= cyc_wrdata[2];
                        dis_regs <= cyc_wrdata[0];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== kbbuf.sv ====
module kbbuf (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [aqp_pkg::DATA_W-1:0] kb_data,
    input  logic                       kb_wr,
    input  logic                       kb_pop,
    input  logic                       kb_clear,
    output logic [aqp_pkg::DATA_W-1:0] kb_head,
    output logic                       kb_empty
);

    logic [aqp_pkg::DATA_W-1:0]    mem [aqp_pkg::KBBUF_DEPTH];
    logic [aqp_pkg::KBBUF_PTR_W-1:0] wr_ptr;
    logic [aqp_pkg::KBBUF_PTR_W-1:0] rd_ptr;
    logic [aqp_pkg::KBBUF_PTR_W:0]   count;
    logic                            push;
    logic                            pop;

    assign kb_empty = (count == '0);
    assign push     = kb_wr && count != (aqp_pkg::KBBUF_PTR_W + 1)'(aqp_pkg::KBBUF_DEPTH);
    assign pop      = kb_pop && !kb_empty;            // Pop on empty is ignored
    assign kb_head  = kb_empty ? '0 : mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= kb_data;
    end

    // Pointers wrap naturally at a power-of-two depth
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (kb_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    count_in_range: assert property (@(posedge clk) disable iff (reset)
        count <= (aqp_pkg::KBBUF_PTR_W + 1)'(aqp_pkg::KBBUF_DEPTH));

endmodule

// ==== aqp_sysctl.sv ====
module aqp_sysctl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req,
    input  logic                       rd,
    input  logic                       mem,
    input  logic [aqp_pkg::ADDR_W-1:0] addr,
    input  logic [aqp_pkg::DATA_W-1:0] wrdata,
    input  logic [63:0]                keys,
    input  logic [aqp_pkg::DATA_W-1:0] kb_data,
    input  logic                       kb_wr,
    input  logic                       cassette_in,
    input  logic                       printer_in,
    output logic                       ack,
    output logic [aqp_pkg::DATA_W-1:0] rddata,
    output logic [aqp_pkg::BA_W-1:0]   ba,
    output logic                       ram_ce_n,
    output logic                       cart_ce_n,
    output logic                       ram_we_n,
    output logic                       phi,
    output logic                       cassette_out,
    output logic                       printer_out,
    output logic                       reset_req
);

    logic                       cyc_active, cyc_rd, cyc_mem;
    logic [aqp_pkg::ADDR_W-1:0] cyc_addr;
    logic [aqp_pkg::DATA_W-1:0] cyc_wrdata;
    logic                       rd_stb, wr_stb;
    aqp_pkg::io_sel_t           io_sel;
    logic [1:0]                 bank_idx;
    aqp_pkg::bank_set_t         banks;
    logic                       dis_regs, turbo;
    logic                       kb_pop, kb_clear, kb_empty;
    logic [aqp_pkg::DATA_W-1:0] kb_head;

    //////////////////////////////////////////////////////////////////////
    // Bus side
    //////////////////////////////////////////////////////////////////////
    bus_cycle_fsm u_fsm (
        .clk(clk), .reset(reset), .req(req), .rd(rd), .mem(mem), .addr(addr),
        .wrdata(wrdata), .ack(ack), .cyc_active(cyc_active), .cyc_rd(cyc_rd),
        .cyc_mem(cyc_mem), .cyc_addr(cyc_addr), .cyc_wrdata(cyc_wrdata),
        .rd_stb(rd_stb), .wr_stb(wr_stb));

    addr_decode u_decode (
        .cyc_active(cyc_active), .cyc_rd(cyc_rd), .cyc_mem(cyc_mem),
        .cyc_addr(cyc_addr), .banks(banks), .dis_regs(dis_regs), .io_sel(io_sel),
        .bank_idx(bank_idx), .ba(ba), .ram_ce_n(ram_ce_n), .cart_ce_n(cart_ce_n),
        .ram_we_n(ram_we_n));

    //////////////////////////////////////////////////////////////////////
    // Registers, keyboard buffer and bus clock
    //////////////////////////////////////////////////////////////////////
    io_regs u_regs (
        .clk(clk), .reset(reset), .rd_stb(rd_stb), .wr_stb(wr_stb),
        .io_sel(io_sel), .bank_idx(bank_idx), .cyc_addr(cyc_addr),
        .cyc_wrdata(cyc_wrdata), .keys(keys), .cassette_in(cassette_in),
        .printer_in(printer_in), .kb_head(kb_head), .kb_empty(kb_empty),
        .banks(banks), .dis_regs(dis_regs), .turbo(turbo),
        .cassette_out(cassette_out), .printer_out(printer_out),
        .reset_req(reset_req), .kb_pop(kb_pop), .kb_clear(kb_clear),
        .rddata(rddata));

    kbbuf u_kbbuf (
        .clk(clk), .reset(reset), .kb_data(kb_data), .kb_wr(kb_wr),
        .kb_pop(kb_pop), .kb_clear(kb_clear), .kb_head(kb_head),
        .kb_empty(kb_empty));

    phi_timer u_phi (
        .clk(clk), .reset(reset), .turbo(turbo), .phi(phi));

endmodule

// ==== tb_aqp_sysctl.sv ====
module tb_aqp_sysctl;

    localparam int NUM_TESTS       = 7;
    localparam int CYCLES_PER_TEST = 200;
    localparam int ACK_BOUND       = 20;
    localparam int PHI_BOUND       = 20;
    // Bank values for the first memory round: internal, cart, RAM, read-only RAM
    localparam logic [31:0] DIRECTED_BANKS = 32'hA8_21_11_02;

    logic                       clk;
    logic                       reset;
    logic                       req;
    logic                       rd;
    logic                       mem;
    logic [aqp_pkg::ADDR_W-1:0] addr;
    logic [aqp_pkg::DATA_W-1:0] wrdata;
    logic [63:0]                keys;
    logic [aqp_pkg::DATA_W-1:0] kb_data;
    logic                       kb_wr;
    logic                       cassette_in;
    logic                       printer_in;
    logic                       ack;
    logic [aqp_pkg::DATA_W-1:0] rddata;
    logic [aqp_pkg::BA_W-1:0]   ba;
    logic                       ram_ce_n;
    logic                       cart_ce_n;
    logic                       ram_we_n;
    logic                       phi;
    logic                       cassette_out;
    logic                       printer_out;
    logic                       reset_req;

    logic [15:0] lfsr_state = 16'd6594;
    int          reset_pulses = 0;

    aqp_sysctl uut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (reset_req)
            reset_pulses++;                     // One count per cycle high
    end

    ///////////////////////////////////////////////////////////////////////
    // Random bits and failure reporting
    ///////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[62:0], fb};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("** Error @ %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped: %s at time %0t", why, $time);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input logic [aqp_pkg::DATA_W-1:0] got,
                              input logic [aqp_pkg::DATA_W-1:0] exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %02h, expected %02h", what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    // Enables as {ram_ce_n, cart_ce_n, ram_we_n}
    task automatic check_ce(input logic [2:0] got, input logic [2:0] exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %03b, expected %03b", what, got, exp));
    endtask

    task automatic check_ba(input logic [aqp_pkg::BA_W-1:0] got,
                            input logic [aqp_pkg::BA_W-1:0] exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %02h, expected %02h", what, got, exp));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Bus driver
    ///////////////////////////////////////////////////////////////////////

    // Full four-phase cycle, outputs sampled while ack is high
    task automatic run_cycle(input logic is_rd, input logic is_mem,
                             input logic [aqp_pkg::ADDR_W-1:0] a,
                             input logic [aqp_pkg::DATA_W-1:0] d,
                             output logic [aqp_pkg::DATA_W-1:0] rdat,
                             output logic [aqp_pkg::BA_W-1:0] bav, output logic [2:0] ce);
        int waited;
        @(posedge clk);
        rd     <= is_rd;
        mem    <= is_mem;
        addr   <= a;
        wrdata <= d;
        req    <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_BOUND)
                abort_run("ack never rose");
        end while (!ack);
        rdat = rddata;
        bav  = ba;
        ce   = {ram_ce_n, cart_ce_n, ram_we_n};
        @(posedge clk);
        req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_BOUND)
                abort_run("ack never fell");
        end while (ack);
    endtask

    task automatic bus_write(input logic [aqp_pkg::ADDR_W-1:0] a,
                             input logic [aqp_pkg::DATA_W-1:0] d);
        logic [aqp_pkg::DATA_W-1:0] unused_rd;
        logic [aqp_pkg::BA_W-1:0]   unused_ba;
        logic [2:0]                 unused_ce;
        run_cycle(1'b0, 1'b0, a, d, unused_rd, unused_ba, unused_ce);
    endtask

    task automatic bus_read(input logic [aqp_pkg::ADDR_W-1:0] a,
                            output logic [aqp_pkg::DATA_W-1:0] rdat);
        logic [aqp_pkg::BA_W-1:0] unused_ba;
        logic [2:0]               unused_ce;
        run_cycle(1'b1, 1'b0, a, '0, rdat, unused_ba, unused_ce);
    endtask

    task automatic push_key(input logic [aqp_pkg::DATA_W-1:0] d);
        @(posedge clk);
        kb_data <= d;
        kb_wr   <= 1'b1;
        @(posedge clk);
        kb_wr   <= 1'b0;
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Directed tests
    ///////////////////////////////////////////////////////////////////////

    // Exact edge timing of the req/ack handshake
    task automatic test_handshake;
        @(posedge clk);
        rd   <= 1'b1;
        mem  <= 1'b0;
        addr <= 16'h0000;                       // Undecoded port
        req  <= 1'b1;
        for (int n = 0; n <= 4; n++) begin
            @(negedge clk);
            check_bit(ack, n == 4, $sformatf("ack after edge %0d", n));
        end
        repeat (10) begin
            @(negedge clk);
            check_bit(ack, 1'b1, "ack held with req high");
            check_byte(rddata, aqp_pkg::READ_IDLE, "rddata held");
        end
        @(posedge clk);
        req <= 1'b0;
        for (int n = 0; n <= 3; n++) begin
            @(negedge clk);
            check_bit(ack, n < 3, $sformatf("ack %0d edges after req fell", n));
        end
    endtask

    task automatic test_banks;
        logic [7:0]  vals [4];
        logic [7:0]  got;
        logic [63:0] r;
        for (int i = 0; i < 4; i++) begin
            r = random_bits(8);
            vals[i] = r[7:0];
            bus_write(16'h00F0 + i, vals[i]);
        end
        for (int i = 0; i < 4; i++) begin
            bus_read(16'h00F0 + i, got);
            check_byte(got, vals[i], "bank readback");
        end
        bus_write(16'h00FB, 8'h01);             // Registers disabled
        bus_read(16'h00FB, got);
        check_byte(got, 8'h01, "sysctrl readback");
        for (int i = 0; i < 4; i++) begin
            bus_read(16'h00F0 + i, got);
            check_byte(got, aqp_pkg::READ_IDLE, "disabled bank read");
            bus_write(16'h00F0 + i, ~vals[i]);
        end
        bus_write(16'h00FB, 8'h00);
        for (int i = 0; i < 4; i++) begin
            bus_read(16'h00F0 + i, got);
            check_byte(got, vals[i], "bank kept while disabled");
        end
    endtask

    function automatic logic [2:0] expected_enables(input logic [7:0] bank,
                                                    input logic is_write);
        logic [5:0] page;
        logic       ram;
        logic       cart;
        page = bank[5:0];
        ram  = page >= aqp_pkg::PAGE_RAM_FIRST;
        cart = page >= aqp_pkg::PAGE_CART_FIRST && page <= aqp_pkg::PAGE_CART_LAST;
        return {!ram, !cart, !(ram && is_write && !bank[7])};
    endfunction

    task automatic test_memory;
        logic [7:0]                 bank_vals [4];
        logic [aqp_pkg::ADDR_W-1:0] a;
        logic [aqp_pkg::DATA_W-1:0] got;
        logic [aqp_pkg::BA_W-1:0]   bav;
        logic [2:0]                 ce;
        logic [63:0]                r;
        for (int round = 0; round < 2; round++) begin
            for (int q = 0; q < 4; q++) begin
                if (round == 0) begin
                    bank_vals[q] = DIRECTED_BANKS[q*8 +: 8];
                end else begin
                    r = random_bits(8);
                    bank_vals[q] = r[7:0];
                end
                bus_write(16'h00F0 + q, bank_vals[q]);
            end
            for (int q = 0; q < 4; q++) begin
                for (int w = 0; w < 2; w++) begin
                    r = random_bits(14);
                    a = {q[1:0], r[13:0]};
                    r = random_bits(8);
                    run_cycle(w == 0, 1'b1, a, r[7:0], got, bav, ce);
                    check_ba(bav, bank_vals[q][4:0], "bank address");
                    check_ce(ce, expected_enables(bank_vals[q], w == 1), "memory enables");
                    if (w == 0)
                        check_byte(got, aqp_pkg::READ_IDLE, "memory read data");
                end
            end
        end
        @(negedge clk);
        check_ce({ram_ce_n, cart_ce_n, ram_we_n}, 3'b111, "enables between cycles");
    endtask

    task automatic test_io_pins;
        logic [7:0] got;
        int         start;
        for (int v = 1; v >= 0; v--) begin
            bus_write(16'h00FC, 8'(v));
            check_bit(cassette_out, v[0], "cassette_out");
            bus_write(16'h00FE, 8'(v));
            check_bit(printer_out, v[0], "printer_out");
        end
        for (int v = 0; v < 2; v++) begin
            @(posedge clk);
            cassette_in <= v[0];
            printer_in  <= !v[0];
            repeat (5) @(posedge clk);          // Past the input synchronizers
            bus_read(16'h00FC, got);
            check_byte(got, {7'b0, !v[0]}, "cassette read");
            bus_read(16'h00FE, got);
            check_byte(got, {7'b0, !v[0]}, "printer read");
        end
        start = reset_pulses;
        bus_write(16'h00FB, 8'h80);
        repeat (3) @(negedge clk);
        check_count(reset_pulses - start, 1, "reset_req cycles high");
    endtask

    task automatic test_keyboard;
        logic [63:0] r;
        logic [63:0] high;
        logic [7:0]  exp;
        logic [7:0]  got;
        for (int t = 0; t < 8; t++) begin
            r    = random_bits(64);
            high = random_bits(8);
            @(posedge clk);
            keys <= r;
            exp = 8'hFF;
            for (int row = 0; row < 8; row++) begin
                if (!high[row])
                    exp = exp & r[row*8 +: 8];  // Selected rows are ANDed
            end
            bus_read({high[7:0], 8'hFF}, got);
            check_byte(got, exp, "keyboard matrix");
        end
    endtask

    task automatic test_kbbuf;
        logic [7:0]  pushed [$];
        logic [7:0]  got;
        logic [63:0] r;
        for (int i = 0; i < 3; i++) begin
            r = random_bits(8);
            push_key(r[7:0]);
            pushed.push_back(r[7:0]);
        end
        for (int i = 0; i < 3; i++) begin
            bus_read(16'h00FA, got);
            check_byte(got, pushed[i], "buffer order");
        end
        bus_read(16'h00FA, got);
        check_byte(got, 8'h00, "empty buffer");
        pushed.delete();
        for (int i = 0; i < 17; i++) begin
            r = random_bits(8);
            push_key(r[7:0]);
            if (i < aqp_pkg::KBBUF_DEPTH)
                pushed.push_back(r[7:0]);       // Last push is dropped
        end
        for (int i = 0; i < aqp_pkg::KBBUF_DEPTH; i++) begin
            bus_read(16'h00FA, got);
            check_byte(got, pushed[i], "full buffer order");
        end
        bus_read(16'h00FA, got);
        check_byte(got, 8'h00, "buffer empty after overfill");
        push_key(8'h5A);
        push_key(8'hA5);
        bus_write(16'h00FA, 8'h00);
        bus_read(16'h00FA, got);
        check_byte(got, 8'h00, "buffer cleared");
    endtask

    // Cycles from one phi toggle to the next
    task automatic measure_half(output int cycles);
        logic prev;
        int   waited;
        prev   = phi;
        waited = 0;
        while (phi == prev) begin
            @(negedge clk);
            waited++;
            if (waited > PHI_BOUND)
                abort_run("phi stopped toggling");
        end
        prev   = phi;
        cycles = 0;
        while (phi == prev) begin
            @(negedge clk);
            cycles++;
            if (cycles > PHI_BOUND)
                abort_run("phi stopped toggling");
        end
    endtask

    task automatic test_phi;
        int cycles;
        repeat (2) begin
            measure_half(cycles);
            check_count(cycles, aqp_pkg::PHI_HALF_NORMAL, "phi half period");
        end
        bus_write(16'h00FB, 8'h04);
        repeat (2) begin
            measure_half(cycles);
            check_count(cycles, aqp_pkg::PHI_HALF_TURBO, "turbo phi half period");
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ///////////////////////////////////////////////////////////////////////
    initial begin
        reset       = 1'b1;
        req         = 1'b0;
        rd          = 1'b0;
        mem         = 1'b0;
        addr        = '0;
        wrdata      = '0;
        keys        = '1;                       // No key pressed
        kb_data     = '0;
        kb_wr       = 1'b0;
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_handshake();
        test_banks();
        test_memory();
        test_io_pins();
        test_keyboard();
        test_kbbuf();
        test_phi();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        repeat (10 + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

endmodule

// ==== all.f ====
aqp_pkg.sv
bus_cycle_fsm.sv
phi_timer.sv
addr_decode.sv
io_regs.sv
kbbuf.sv
aqp_sysctl.sv
tb_aqp_sysctl.sv
